// File: src/icache_pkg.sv
/*
 * Shared widths, page geometry and types for the instruction page cache.
 * One page is 1 KB of code held as 256 words of 32 bits.
 * Addresses are byte addresses, and fetches are assumed word aligned.
 */

package icache_pkg;

    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int PAGE_OFFSET_W  = 10;
    localparam int PAGE_W         = ADDR_W - PAGE_OFFSET_W;
    localparam int LINE_ADDR_W    = 8;
    localparam int WORDS_PER_PAGE = 256;
    localparam int BUBBLE_CYCLES  = 5;

    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [PAGE_W-1:0]      page_t;
    typedef logic [LINE_ADDR_W-1:0] ram_addr_t;

    // Miss handling sequence, one state per step of the fill
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_BUBBLE,
        ST_PAGE_SEL,
        ST_LOAD_ADDR,
        ST_FETCH,
        ST_UPDATE
    } fill_state_e;

endpackage

// File: src/fill_if.sv
/*
 * Code RAM write traffic from the fill sequencer.
 * No handshake: wr_en is a single-cycle strobe per word.
 * last_word pulses together with the final write of a page fill.
 */

interface fill_if
    import icache_pkg::*;
();

    logic      wr_en;
    ram_addr_t wr_addr;
    word_t     wr_data;
    logic      last_word;

    modport sequencer (
        output wr_en,
        output wr_addr,
        output wr_data,
        output last_word
    );

    modport ram (
        input wr_en,
        input wr_addr,
        input wr_data
    );

    modport ctrl (
        input last_word
    );

endinterface

// File: src/fill_ctrl.sv
/*
 * Miss handling FSM for the page cache.
 * A miss seen while idle gives five bubble cycles, then a page fill.
 * The fill waits for last_word however long the SPI master takes.
 * Clock enable and miss are combinational from the hit input.
 */

module fill_ctrl
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   i_hit,
    fill_if.ctrl   fill_bus,
    output logic   o_latch_page,
    output logic   o_load_addr,
    output logic   o_fetching,
    output logic   o_commit,
    output logic   o_core_bubble,
    output logic   o_clk_enable,
    output logic   o_icache_miss
);

    fill_state_e state;
    fill_state_e state_next;

    logic [$clog2(BUBBLE_CYCLES)-1:0] bubble_cnt;
    logic                             bubble_done;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // Counts only while in the bubble state, held at zero otherwise
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bubble_cnt <= '0;
        end
        else if (state == ST_BUBBLE)
        begin
            bubble_cnt <= bubble_cnt + 1'b1;
        end
        else
        begin
            bubble_cnt <= '0;
        end
    end

    assign bubble_done = (int'(bubble_cnt) == BUBBLE_CYCLES - 1);

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
            begin
                if (!i_hit)
                begin
                    state_next = ST_BUBBLE;
                end
            end
            ST_BUBBLE:
            begin
                if (bubble_done)
                begin
                    state_next = ST_PAGE_SEL;
                end
            end
            ST_PAGE_SEL:  state_next = ST_LOAD_ADDR;
            ST_LOAD_ADDR: state_next = ST_FETCH;
            ST_FETCH:
            begin
                if (fill_bus.last_word)
                begin
                    state_next = ST_UPDATE;
                end
            end
            ST_UPDATE:    state_next = ST_IDLE;
            default:      state_next = ST_IDLE;
        endcase
    end

    // Strobes decoded straight from the state
    assign o_core_bubble = (state == ST_BUBBLE);
    assign o_latch_page  = (state == ST_PAGE_SEL);
    assign o_load_addr   = (state == ST_LOAD_ADDR);
    assign o_fetching    = (state == ST_FETCH);
    assign o_commit      = (state == ST_UPDATE);

    // Core runs only when idle and the fetch lands in the window
    assign o_clk_enable  = (state == ST_IDLE) && i_hit;
    assign o_icache_miss = !i_hit;

endmodule

// File: src/page_window.sv
/*
 * Base/bound window of the cached page and the pending page of a fill.
 * Base and bound reset to all ones, so every PC misses after reset.
 * The bound wraps to zero for the topmost page, which never hits.
 */

module page_window
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  addr_t i_pc_fetch,
    input  logic  i_latch_page,
    input  logic  i_commit,
    output page_t o_pending_page,
    output logic  o_hit
);

    addr_t base;
    addr_t bound;
    addr_t pending_base;

    // Page of the missing PC, captured before the fill starts
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_pending_page <= '0;
        end
        else if (i_latch_page)
        begin
            o_pending_page <= i_pc_fetch[ADDR_W-1:PAGE_OFFSET_W];
        end
    end

    assign pending_base = {o_pending_page, {PAGE_OFFSET_W{1'b0}}};

    // Window moves only once the whole page is in the RAM
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            base  <= '1;
            bound <= '1;
        end
        else if (i_commit)
        begin
            base  <= pending_base;
            bound <= pending_base + (addr_t'(1) << PAGE_OFFSET_W);
        end
    end

    assign o_hit = (i_pc_fetch >= base) && (i_pc_fetch < bound);

endmodule

// File: src/fill_sequencer.sv
/*
 * SPI address generation and code RAM writes for one page fill.
 * Each ready pulse while fetching writes the word at the current address,
 * then the address steps by one word at the next edge.
 * last_word marks the 256th write since the last address load.
 */

module fill_sequencer
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  i_load_addr,
    input  logic  i_fetching,
    input  page_t i_pending_page,
    input  word_t i_spi_fetch,
    input  logic  i_spi_ready,
    output addr_t o_spi_address,
    fill_if.sequencer fill_bus
);

    ram_addr_t word_cnt;
    logic      wr_strobe;

    assign wr_strobe = i_fetching && i_spi_ready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_spi_address <= '0;
            word_cnt      <= '0;
        end
        else if (i_load_addr)
        begin
            o_spi_address <= {i_pending_page, {PAGE_OFFSET_W{1'b0}}};
            word_cnt      <= '0;
        end
        else if (wr_strobe)
        begin
            o_spi_address <= o_spi_address + addr_t'(4);
            word_cnt      <= word_cnt + 1'b1;
        end
    end

    // Write uses the address the word was requested for
    assign fill_bus.wr_en     = wr_strobe;
    assign fill_bus.wr_addr   = o_spi_address[PAGE_OFFSET_W-1:2];
    assign fill_bus.wr_data   = i_spi_fetch;
    assign fill_bus.last_word = wr_strobe && (word_cnt == ram_addr_t'(WORDS_PER_PAGE - 1));

endmodule

// File: src/code_ram.sv
/*
 * 256 x 32 synchronous code RAM with one cycle of read latency.
 * Read index is pc[9:2] every cycle; the output is zeroed when
 * the PC of the previous edge missed the window.
 */

module code_ram
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  addr_t i_pc_fetch,
    input  logic  i_hit,
    fill_if.ram   fill_bus,
    output word_t o_code_fetch
);

    word_t mem [WORDS_PER_PAGE];
    word_t rd_data;
    logic  hit_q;

    always_ff @(posedge clk)
    begin
        if (fill_bus.wr_en)
        begin
            mem[fill_bus.wr_addr] <= fill_bus.wr_data;
        end
        rd_data <= mem[i_pc_fetch[PAGE_OFFSET_W-1:2]];
    end

    // Hit aligned with the read data
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hit_q <= 1'b0;
        end
        else
        begin
            hit_q <= i_hit;
        end
    end

    assign o_code_fetch = hit_q ? rd_data : '0;

endmodule

// File: src/icache_top.sv
/*
 * Instruction page cache with a single 1 KB window of code.
 * A miss stalls the core and refills the whole page from the SPI master.
 * i_pc_fetch must stay stable while o_clk_enable is low.
 * o_code_fetch lags the PC by one clock edge.
 */

module icache_top
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    // Core fetch side
    input  addr_t i_pc_fetch,
    output word_t o_code_fetch,
    // SPI master side
    input  word_t i_spi_fetch,
    input  logic  i_spi_ready,
    output addr_t o_spi_address,
    output logic  o_spi_addr_valid,
    // Core clock gating and stall
    output logic  o_clk_enable,
    output logic  o_icache_miss,
    output logic  o_core_bubble
);

    logic  hit;
    logic  latch_page;
    logic  load_addr;
    logic  fetching;
    logic  commit;
    page_t pending_page;

    fill_if fill_bus ();

    fill_ctrl i_fill_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_hit         (hit),
        .fill_bus      (fill_bus.ctrl),
        .o_latch_page  (latch_page),
        .o_load_addr   (load_addr),
        .o_fetching    (fetching),
        .o_commit      (commit),
        .o_core_bubble (o_core_bubble),
        .o_clk_enable  (o_clk_enable),
        .o_icache_miss (o_icache_miss)
    );

    page_window i_page_window (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_pc_fetch     (i_pc_fetch),
        .i_latch_page   (latch_page),
        .i_commit       (commit),
        .o_pending_page (pending_page),
        .o_hit          (hit)
    );

    fill_sequencer i_fill_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_load_addr    (load_addr),
        .i_fetching     (fetching),
        .i_pending_page (pending_page),
        .i_spi_fetch    (i_spi_fetch),
        .i_spi_ready    (i_spi_ready),
        .o_spi_address  (o_spi_address),
        .fill_bus       (fill_bus.sequencer)
    );

    code_ram i_code_ram (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_pc_fetch   (i_pc_fetch),
        .i_hit        (hit),
        .fill_bus     (fill_bus.ram),
        .o_code_fetch (o_code_fetch)
    );

    // The SPI master is only allowed to answer while the FSM is fetching
    assign o_spi_addr_valid = fetching;

endmodule

// File: dv/icache_sva.sv
/*
 * Consistency checks on the core-facing control outputs of the cache.
 * Bound into every icache_top instance; checks are off during reset.
 */

module icache_sva (
    input logic clk,
    input logic rst_n,
    input logic i_core_bubble,
    input logic i_spi_addr_valid,
    input logic i_clk_enable,
    input logic i_icache_miss
);

    // Bubble and fill phases never overlap
    a_bubble_not_fetching: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(i_core_bubble && i_spi_addr_valid)
    ) else $error("core bubble and SPI address valid both high");

    // Running core implies the PC is in the window
    a_enable_means_hit: assert property (
        @(posedge clk) disable iff (!rst_n)
        i_clk_enable |-> !i_icache_miss
    ) else $error("clock enable high while the fetch misses");

    // Page select and address load sit between bubble and fill
    a_no_fetch_after_bubble: assert property (
        @(posedge clk) disable iff (!rst_n)
        i_core_bubble |=> !i_spi_addr_valid
    ) else $error("SPI address valid directly after a bubble cycle");

endmodule

bind icache_top icache_sva i_icache_sva (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_core_bubble    (o_core_bubble),
    .i_spi_addr_valid (o_spi_addr_valid),
    .i_clk_enable     (o_clk_enable),
    .i_icache_miss    (o_icache_miss)
);

// File: dv/tb_icache.sv
/*
 * Testbench for the instruction page cache with a random SPI master.
 * Each fill loads random words into a model page, then random hits are
 * checked against it. Every other fill revisits the page just replaced.
 * Inputs change 2 time units after the rising edge; stops at first error.
 */

module tb_icache
    import icache_pkg::*;
#(
    parameter logic [31:0] SEED = 32'hc8b0_4917
);

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DLY      = 2;
    localparam int RESET_CYCLES   = 5;
    localparam int NUM_FILLS      = 8;
    localparam int READS_PER_FILL = 200;
    localparam int MAX_CYCLES     = NUM_FILLS * (WORDS_PER_PAGE * 4 + 20) + 2000;

    logic  clk;
    logic  rst_n;
    addr_t i_pc_fetch;
    word_t o_code_fetch;
    word_t i_spi_fetch;
    logic  i_spi_ready;
    addr_t o_spi_address;
    logic  o_spi_addr_valid;
    logic  o_clk_enable;
    logic  o_icache_miss;
    logic  o_core_bubble;

    integer seed;
    integer cycle_cnt;
    word_t  model [WORDS_PER_PAGE];

    icache_top i_icache_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_pc_fetch       (i_pc_fetch),
        .o_code_fetch     (o_code_fetch),
        .i_spi_fetch      (i_spi_fetch),
        .i_spi_ready      (i_spi_ready),
        .o_spi_address    (o_spi_address),
        .o_spi_addr_valid (o_spi_addr_valid),
        .o_clk_enable     (o_clk_enable),
        .o_icache_miss    (o_icache_miss),
        .o_core_bubble    (o_core_bubble)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected)
        begin
            abort_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic check_addr(input string name, input addr_t actual, input addr_t expected);
        if (actual !== expected)
        begin
            abort_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            abort_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    // Miss, bubble, page fill and window move for one page
    task automatic run_fill(input page_t pg);
        addr_t base;
        int    gap;
        base = {pg, {PAGE_OFFSET_W{1'b0}}};
        i_pc_fetch = base | addr_t'({ram_addr_t'($random(seed)), 2'b00});
        @(negedge clk);
        check_bit("o_icache_miss", o_icache_miss, 1'b1);
        check_bit("o_clk_enable", o_clk_enable, 1'b0);
        check_bit("o_core_bubble", o_core_bubble, 1'b0);
        repeat (BUBBLE_CYCLES)
        begin
            @(negedge clk);
            check_bit("o_core_bubble", o_core_bubble, 1'b1);
            check_bit("o_spi_addr_valid", o_spi_addr_valid, 1'b0);
            check_bit("o_clk_enable", o_clk_enable, 1'b0);
            // Missing PC gives no code word
            check_word("o_code_fetch", o_code_fetch, '0);
        end
        // Page select, then address load
        repeat (2)
        begin
            @(negedge clk);
            check_bit("o_core_bubble", o_core_bubble, 1'b0);
            check_bit("o_spi_addr_valid", o_spi_addr_valid, 1'b0);
        end
        @(negedge clk);
        check_bit("o_spi_addr_valid", o_spi_addr_valid, 1'b1);
        check_addr("o_spi_address", o_spi_address, base);
        @(posedge clk);
        #DRIVE_DLY;
        for (int w = 0; w < WORDS_PER_PAGE; w++)
        begin
            gap = $random(seed) & 3;
            i_spi_ready = 1'b0;
            repeat (gap)
            begin
                @(posedge clk);
                #DRIVE_DLY;
            end
            check_bit("o_spi_addr_valid", o_spi_addr_valid, 1'b1);
            check_addr("o_spi_address", o_spi_address, base + addr_t'(4 * w));
            model[w] = word_t'($random(seed));
            i_spi_fetch = model[w];
            i_spi_ready = 1'b1;
            @(posedge clk);
            #DRIVE_DLY;
        end
        i_spi_ready = 1'b0;
        check_bit("o_spi_addr_valid", o_spi_addr_valid, 1'b0);
        @(negedge clk);
        check_bit("o_clk_enable", o_clk_enable, 1'b0);
        @(negedge clk);
        check_bit("o_clk_enable", o_clk_enable, 1'b1);
        check_bit("o_icache_miss", o_icache_miss, 1'b0);
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Random word reads inside the loaded page
    task automatic check_reads(input page_t pg, input int count);
        ram_addr_t idx;
        for (int i = 0; i < count; i++)
        begin
            idx = ram_addr_t'($random(seed));
            i_pc_fetch = {pg, idx, 2'b00};
            @(negedge clk);
            check_bit("o_clk_enable", o_clk_enable, 1'b1);
            check_bit("o_icache_miss", o_icache_miss, 1'b0);
            @(posedge clk);
            #DRIVE_DLY;
            check_word("o_code_fetch", o_code_fetch, model[idx]);
        end
    endtask

    initial
    begin
        cycle_cnt = 0;
        forever
        begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt > MAX_CYCLES)
            begin
                abort_run($sformatf("Timeout: no end of test after %0d cycles", MAX_CYCLES));
            end
        end
    end

    initial
    begin
        page_t cur_page;
        page_t prev_page;
        page_t pg;
        seed        = SEED;
        rst_n       = 1'b0;
        i_pc_fetch  = '0;
        i_spi_fetch = '0;
        i_spi_ready = 1'b0;
        cur_page    = '1;
        prev_page   = '1;
        // Window is all ones in reset, so any PC misses
        repeat (RESET_CYCLES)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            i_pc_fetch = addr_t'($random(seed));
            @(negedge clk);
            check_bit("o_icache_miss", o_icache_miss, 1'b1);
            check_bit("o_clk_enable", o_clk_enable, 1'b0);
            check_bit("o_core_bubble", o_core_bubble, 1'b0);
            check_bit("o_spi_addr_valid", o_spi_addr_valid, 1'b0);
        end
        @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        for (int f = 0; f < NUM_FILLS; f++)
        begin
            if (f >= 2 && (f % 2) == 0)
            begin
                pg = prev_page;
            end
            else
            begin
                pg = page_t'($random(seed));
                // Topmost page never hits
                while (pg == cur_page || pg == '1)
                begin
                    pg = page_t'($random(seed));
                end
            end
            run_fill(pg);
            check_reads(pg, READS_PER_FILL);
            prev_page = cur_page;
            cur_page  = pg;
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: icache_top.f
src/icache_pkg.sv
src/fill_if.sv
src/fill_ctrl.sv
src/page_window.sv
src/fill_sequencer.sv
src/code_ram.sv
src/icache_top.sv
dv/icache_sva.sv
dv/tb_icache.sv

// File: Makefile
# Verilator simulation of the instruction page cache
# Override on the command line, e.g. make sim SEED=32'h0000_1234

VERILATOR ?= verilator
TOP       ?= tb_icache
SEED      ?= 32'hc8b04917
FILELIST  ?= icache_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) "-GSEED=$(SEED)" \
		-f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
